//--- hdl/epl_shim_settings.svh
`ifndef EPL_SHIM_SETTINGS_SVH
`define EPL_SHIM_SETTINGS_SVH

// ----------------------------------------------------------
// Port group shape
// ----------------------------------------------------------

// Logical ports sharing one TX channel
`define EPL_NUM_PORTS 4

// Width of the port configuration code from the CSR
`define EPL_CFG_W 4

// ----------------------------------------------------------
// Channel data path
// ----------------------------------------------------------

`define EPL_FLITS   8   // Flits per clock
`define EPL_FLIT_W  72  // 64 data bits plus 8 ECC bits
`define EPL_META_W  24  // Per-cycle metadata, SOP/EOP inside
`define EPL_ECC_W   8   // ECC over data_valid and metadata

`endif

//--- hdl/epl_shim_pkg.sv
`include "epl_shim_settings.svh"

package epl_shim_pkg;

  // ----------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------

  typedef logic [$clog2(`EPL_NUM_PORTS)-1:0] port_num_t;  // Logical port
  typedef logic [`EPL_CFG_W-1:0]             port_cfg_t;  // CSR config code
  typedef logic [`EPL_FLITS-1:0]             flit_mask_t; // One bit per flit
  typedef logic [`EPL_FLIT_W-1:0]            flit_t;      // Data with ECC byte
  typedef logic [`EPL_META_W-1:0]            metadata_t;
  typedef logic [`EPL_ECC_W-1:0]             meta_ecc_t;

  // Logical port numbers
  localparam port_num_t PORT0 = 2'd0;
  localparam port_num_t PORT1 = 2'd1;
  localparam port_num_t PORT2 = 2'd2;
  localparam port_num_t PORT3 = 2'd3;

  // Config codes, anything above 4 is reserved
  localparam port_cfg_t CFG_ONE_PORT  = 4'd0; // 0,0,0,0
  localparam port_cfg_t CFG_TWO_PORT  = 4'd1; // 0,2,0,2
  localparam port_cfg_t CFG_FOUR_PORT = 4'd2; // 0,1,2,3
  localparam port_cfg_t CFG_THREE_A   = 4'd3; // 0,2,1,2
  localparam port_cfg_t CFG_THREE_B   = 4'd4; // 0,2,0,3

  // TDM slot state
  typedef enum logic [1:0] {
    SLOT0 = 2'd0,
    SLOT1 = 2'd1,
    SLOT2 = 2'd2,
    SLOT3 = 2'd3
  } tdm_slot_e;

  // ----------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------

  // One cycle of channel traffic, ECC passed through untouched
  typedef struct packed {
    flit_mask_t                data_valid; // Valid flits
    metadata_t                 metadata;   // Framing and TC, opaque here
    meta_ecc_t                 meta_ecc;   // Covers data_valid and metadata
    flit_t [`EPL_FLITS-1:0]    data;       // SOP always in flit 0
  } tx_bundle_t;

  // Port logic enable, aligned to the slot
  typedef struct packed {
    logic      enable;
    port_num_t port;
  } tx_grant_t;

endpackage : epl_shim_pkg

//--- hdl/tdm_slot_sequencer.sv
`timescale 1ns/1ns

module tdm_slot_sequencer (
  input  logic                    clk,
  input  logic                    reset_n,
  input  epl_shim_pkg::port_cfg_t port_config,
  output epl_shim_pkg::port_num_t slot_port
);

  import epl_shim_pkg::*;

  port_cfg_t cfg_q;      // Registered config code
  tdm_slot_e state;
  tdm_slot_e state_nxt;
  logic      cycling;    // Multi-port pattern in use

  // ----------------------------------------------------------
  // Config register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cfg_q <= CFG_ONE_PORT;
    end else begin
      cfg_q <= port_config; // New code active next cycle
    end
  end

  // Single port and reserved codes park in SLOT0
  assign cycling = (cfg_q == CFG_TWO_PORT)  || (cfg_q == CFG_FOUR_PORT) ||
                   (cfg_q == CFG_THREE_A)   || (cfg_q == CFG_THREE_B);

  // ----------------------------------------------------------
  // Slot FSM
  // ----------------------------------------------------------

  always_comb begin
    state_nxt = SLOT0;
    if (cycling) begin
      case (state)
        SLOT0:   state_nxt = SLOT1;
        SLOT1:   state_nxt = SLOT2;
        SLOT2:   state_nxt = SLOT3;
        default: state_nxt = SLOT0; // Wrap after SLOT3
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= SLOT0;
    end else begin
      state <= state_nxt;
    end
  end

  // ----------------------------------------------------------
  // Slot owner decode
  // ----------------------------------------------------------

  always_comb begin
    slot_port = PORT0; // One port and reserved
    case (cfg_q)
      CFG_TWO_PORT: begin
        // Even slots port 0, odd slots port 2
        slot_port = (state == SLOT1 || state == SLOT3) ? PORT2 : PORT0;
      end
      CFG_FOUR_PORT: begin
        slot_port = port_num_t'(state); // Slot number is the port
      end
      CFG_THREE_A: begin
        case (state)
          SLOT0:   slot_port = PORT0;
          SLOT2:   slot_port = PORT1;
          default: slot_port = PORT2; // SLOT1 and SLOT3
        endcase
      end
      CFG_THREE_B: begin
        case (state)
          SLOT1:   slot_port = PORT2;
          SLOT3:   slot_port = PORT3;
          default: slot_port = PORT0; // Port 0 owns half the slots
        endcase
      end
      default: slot_port = PORT0;
    endcase
  end

endmodule : tdm_slot_sequencer

//--- hdl/tx_enable_tracker.sv
`timescale 1ns/1ns

module tx_enable_tracker (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    tx_enable,
  input  epl_shim_pkg::port_num_t tx_enable_port_num,
  output epl_shim_pkg::tx_grant_t grant,
  output logic                    tx_valid_resp
);

  import epl_shim_pkg::*;

  tx_grant_t grant_nxt;

  // Strobe and port number travel together
  assign grant_nxt = '{enable: tx_enable, port: tx_enable_port_num};

  // ----------------------------------------------------------
  // Grant stage, lines the strobe up with the slot
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      grant <= '0;
    end else begin
      grant <= grant_nxt;
    end
  end

  // ----------------------------------------------------------
  // Credit return
  // ----------------------------------------------------------

  // Every strobe comes back as a credit two cycles later
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tx_valid_resp <= 1'b0;
    end else begin
      tx_valid_resp <= grant.enable; // Second delay stage
    end
  end

endmodule : tx_enable_tracker

//--- hdl/epl_tx_mux.sv
`timescale 1ns/1ns
`include "epl_shim_settings.svh"

module epl_tx_mux (
  input  logic                                           clk,
  input  logic                                           reset_n,
  input  epl_shim_pkg::port_num_t                        slot_port,
  input  epl_shim_pkg::tx_grant_t                        grant,
  input  epl_shim_pkg::tx_bundle_t [`EPL_NUM_PORTS-1:0]  port_bundles,
  input  logic [`EPL_NUM_PORTS-1:0]                      tc_rdy,
  output logic [`EPL_NUM_PORTS-1:0]                      buf_ren,
  output logic                                           port_num_err,
  output epl_shim_pkg::tx_bundle_t                       tx_out,
  output epl_shim_pkg::port_num_t                        tx_port_num
);

  import epl_shim_pkg::*;

  tx_bundle_t owner_bundle; // Bundle of the slot owner
  logic       grant_hit;    // Grant names the slot owner
  logic       grant_miss;   // Grant names some other port

  // ----------------------------------------------------------
  // Grant against slot owner
  // ----------------------------------------------------------

  assign grant_hit  = grant.enable && (grant.port == slot_port);
  assign grant_miss = grant.enable && (grant.port != slot_port);

  // Wrong port in this slot, to CSR status
  assign port_num_err = grant_miss;

  // ----------------------------------------------------------
  // Scheduler read enables
  // ----------------------------------------------------------

  // Only the owner bit can fire
  always_comb begin
    for (int p = 0; p < `EPL_NUM_PORTS; p++) begin
      buf_ren[p] = grant_hit && (slot_port == port_num_t'(p)) && tc_rdy[p];
    end
  end

  // ----------------------------------------------------------
  // Channel select and output register
  // ----------------------------------------------------------

  assign owner_bundle = port_bundles[slot_port]; // Whole bundle, ECC included

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tx_out      <= '0;
      tx_port_num <= PORT0;
    end else begin
      tx_out      <= owner_bundle;
      tx_port_num <= slot_port; // Tags the bundle on the channel
    end
  end

endmodule : epl_tx_mux

//--- hdl/epl_shim_top.sv
`timescale 1ns/1ns
`include "epl_shim_settings.svh"

module epl_shim_top (
  input  logic                                           clk,
  input  logic                                           reset_n,
  // Port logic side
  input  logic                                           tx_enable,
  input  epl_shim_pkg::port_num_t                        tx_enable_port_num,
  output logic                                           tx_valid_resp,
  output epl_shim_pkg::tx_bundle_t                       tx_out,
  output epl_shim_pkg::port_num_t                        tx_port_num,
  // Scheduler side
  input  epl_shim_pkg::tx_bundle_t [`EPL_NUM_PORTS-1:0]  port_bundles,
  input  logic [`EPL_NUM_PORTS-1:0]                      tc_rdy,
  output logic [`EPL_NUM_PORTS-1:0]                      buf_ren,
  // CSR
  input  epl_shim_pkg::port_cfg_t                        port_config,
  output logic                                           port_num_err
);

  import epl_shim_pkg::*;

  port_num_t slot_port; // Owner of the current slot
  tx_grant_t grant;     // Enable aligned to the slot

  // ----------------------------------------------------------
  // Slot owner and grant, side by side
  // ----------------------------------------------------------

  tdm_slot_sequencer u_seq (
    .clk         (clk),
    .reset_n     (reset_n),
    .port_config (port_config),
    .slot_port   (slot_port)
  );

  tx_enable_tracker u_trk (
    .clk                (clk),
    .reset_n            (reset_n),
    .tx_enable          (tx_enable),
    .tx_enable_port_num (tx_enable_port_num),
    .grant              (grant),
    .tx_valid_resp      (tx_valid_resp)
  );

  // ----------------------------------------------------------
  // Channel mux
  // ----------------------------------------------------------

  epl_tx_mux u_mux (
    .clk          (clk),
    .reset_n      (reset_n),
    .slot_port    (slot_port),
    .grant        (grant),
    .port_bundles (port_bundles),
    .tc_rdy       (tc_rdy),
    .buf_ren      (buf_ren),
    .port_num_err (port_num_err),
    .tx_out       (tx_out),
    .tx_port_num  (tx_port_num)
  );

endmodule : epl_shim_top

//--- dv/epl_shim_sva.sv
`timescale 1ns/1ns
`include "epl_shim_settings.svh"

module epl_shim_sva (
  input logic                      clk,
  input logic                      reset_n,
  input logic [`EPL_NUM_PORTS-1:0] buf_ren,
  input logic                      port_num_err,
  input logic                      tx_valid_resp,
  input epl_shim_pkg::tx_bundle_t  tx_out,
  input epl_shim_pkg::port_num_t   tx_port_num
);

  // ----------------------------------------------------------
  // Read enable sanity
  // ----------------------------------------------------------

  a_ren_onehot: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0(buf_ren))
    else $error("buf_ren has more than one bit set");

  // A read and a port error in the same slot cannot both happen
  a_ren_no_err: assert property (@(posedge clk) disable iff (!reset_n)
    !((|buf_ren) && port_num_err))
    else $error("buf_ren and port_num_err high together");

  // Quiet outputs one cycle into reset
  a_reset_quiet: assert property (@(posedge clk)
    !reset_n |=> (buf_ren == '0) && !port_num_err && !tx_valid_resp &&
                 (tx_out == '0) && (tx_port_num == '0))
    else $error("outputs not zero after reset");

endmodule : epl_shim_sva

bind epl_shim_top epl_shim_sva sva0 (
  .clk           (clk),
  .reset_n       (reset_n),
  .buf_ren       (buf_ren),
  .port_num_err  (port_num_err),
  .tx_valid_resp (tx_valid_resp),
  .tx_out        (tx_out),
  .tx_port_num   (tx_port_num)
);

//--- dv/tb_epl_shim.sv
`timescale 1ns/1ns
`include "epl_shim_settings.svh"

module tb_epl_shim;

  import epl_shim_pkg::*;

  localparam int NUM_TESTS    = 6;   // Codes 0 to 4 plus one reserved
  localparam int RESET_CYCLES = 8;
  localparam int TEST_CYCLES  = 200;
  localparam int CYCLE_LIMIT  = NUM_TESTS * 220; // Reset plus run, with margin

  logic clk = 1'b0;
  logic reset_n;

  // DUT inputs
  logic                                  tx_enable;
  port_num_t                             tx_enable_port_num;
  tx_bundle_t [`EPL_NUM_PORTS-1:0]       port_bundles;
  logic [`EPL_NUM_PORTS-1:0]             tc_rdy;
  port_cfg_t                             port_config;

  // DUT outputs
  logic                                  tx_valid_resp;
  tx_bundle_t                            tx_out;
  port_num_t                             tx_port_num;
  logic [`EPL_NUM_PORTS-1:0]             buf_ren;
  logic                                  port_num_err;

  // Reference model state, mirrors the registers after each edge
  port_cfg_t  m_cfg;
  logic [1:0] m_slot;
  logic       m_grant_en;
  port_num_t  m_grant_port;
  logic       m_resp;       // Second enable stage
  tx_bundle_t m_out;        // Copy of the owner's bundle
  port_num_t  m_out_port;

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;

  always #20 clk = ~clk; // 40 ns period

  epl_shim_top dut0 (
    .clk                (clk),
    .reset_n            (reset_n),
    .tx_enable          (tx_enable),
    .tx_enable_port_num (tx_enable_port_num),
    .tx_valid_resp      (tx_valid_resp),
    .tx_out             (tx_out),
    .tx_port_num        (tx_port_num),
    .port_bundles       (port_bundles),
    .tc_rdy             (tc_rdy),
    .buf_ren            (buf_ren),
    .port_config        (port_config),
    .port_num_err       (port_num_err)
  );

  // ----------------------------------------------------------
  // Reference helpers
  // ----------------------------------------------------------

  // Slot owner from the TDM pattern table, slot 0 in the low bits
  function automatic port_num_t expected_owner(input port_cfg_t cfg, input logic [1:0] slot);
    logic [7:0] pattern;
    case (cfg)
      4'd1:    pattern = {2'd2, 2'd0, 2'd2, 2'd0}; // 0,2,0,2
      4'd2:    pattern = {2'd3, 2'd2, 2'd1, 2'd0}; // 0,1,2,3
      4'd3:    pattern = {2'd2, 2'd1, 2'd2, 2'd0}; // 0,2,1,2
      4'd4:    pattern = {2'd3, 2'd0, 2'd2, 2'd0}; // 0,2,0,3
      default: pattern = 8'd0;                     // Single port, reserved
    endcase
    return pattern[{slot, 1'b0} +: 2];
  endfunction

  function automatic tx_bundle_t random_bundle();
    tx_bundle_t b;
    b.data_valid = flit_mask_t'($urandom);
    b.metadata   = metadata_t'($urandom);
    b.meta_ecc   = meta_ecc_t'($urandom);
    for (int i = 0; i < `EPL_FLITS; i++) begin
      b.data[i] = {8'($urandom), $urandom, $urandom}; // 72 bits
    end
    return b;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_bundle(input string what, input tx_bundle_t got, input tx_bundle_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got meta %h mask %h, expected meta %h mask %h",
               $time, what, got.metadata, got.data_valid, exp.metadata, exp.data_valid);
    end
  endtask

  task automatic check_port(input string what, input port_num_t got, input port_num_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus and per-cycle check
  // ----------------------------------------------------------

  task automatic drive_random();
    tx_enable          = 1'($urandom);
    tx_enable_port_num = port_num_t'($urandom);
    tc_rdy             = 4'($urandom);
    for (int p = 0; p < `EPL_NUM_PORTS; p++) begin
      port_bundles[p] = random_bundle();
    end
  endtask

  // One falling edge: step the model, compare, drive next inputs
  task automatic run_cycle();
    port_num_t                 owner;
    logic                      cycling;
    logic [`EPL_NUM_PORTS-1:0] exp_ren;
    @(negedge clk);
    owner   = expected_owner(m_cfg, m_slot); // Owner before the edge
    cycling = (m_cfg >= 4'd1) && (m_cfg <= 4'd4);
    if (!reset_n) begin
      m_cfg        = '0;
      m_slot       = 2'd0;
      m_grant_en   = 1'b0;
      m_grant_port = '0;
      m_resp       = 1'b0;
      m_out        = '0;
      m_out_port   = '0;
    end else begin
      m_out        = port_bundles[owner];
      m_out_port   = owner;
      m_resp       = m_grant_en;
      m_grant_en   = tx_enable;
      m_grant_port = tx_enable_port_num;
      m_slot       = cycling ? m_slot + 2'd1 : 2'd0;
      m_cfg        = port_config; // Old code already used above
    end
    // Combinational outputs against the new state
    owner   = expected_owner(m_cfg, m_slot);
    exp_ren = '0;
    if (m_grant_en && (m_grant_port == owner) && tc_rdy[owner]) begin
      exp_ren[owner] = 1'b1;
    end
    check_bundle("tx_out", tx_out, m_out);
    check_port("tx_port_num", tx_port_num, m_out_port);
    for (int p = 0; p < `EPL_NUM_PORTS; p++) begin
      check_bit($sformatf("buf_ren[%0d]", p), buf_ren[p], exp_ren[p]);
    end
    check_bit("port_num_err", port_num_err, m_grant_en && (m_grant_port != owner));
    check_bit("tx_valid_resp", tx_valid_resp, m_resp);
    drive_random();
  endtask

  // Reset, then a run of random traffic under one config code
  task automatic run_test(input int num, input port_cfg_t code);
    int err0;
    int chk0;
    err0    = errors;
    chk0    = checks;
    reset_n = 1'b0;
    repeat (RESET_CYCLES) run_cycle(); // Outputs must stay zero
    port_config = code;
    reset_n     = 1'b1;
    repeat (TEST_CYCLES) run_cycle();
    $display("test %0d cfg %0d done: %0d checks, %0d errors",
             num, code, checks - chk0, errors - err0);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    port_cfg_t reserved;
    void'($urandom(32'h09ba6253));
    reset_n            = 1'b0;
    tx_enable          = 1'b0;
    tx_enable_port_num = '0;
    port_bundles       = '0;
    tc_rdy             = '0;
    port_config        = '0;
    reserved = port_cfg_t'($urandom_range(15, 5)); // Any unused code
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t, (t < 5) ? port_cfg_t'(t) : reserved);
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

endmodule : tb_epl_shim

//--- project.f
+incdir+hdl
hdl/epl_shim_pkg.sv
hdl/tdm_slot_sequencer.sv
hdl/tx_enable_tracker.sv
hdl/epl_tx_mux.sv
hdl/epl_shim_top.sv
dv/epl_shim_sva.sv
dv/tb_epl_shim.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the EPL shim testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_epl_shim -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_epl_shim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q -x -F '>>> PASS'; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
